/* design/fir_regmap_pkg.sv */
/*
 * fir register map
 * byte addresses of the register port and the control/status word,
 * which is decoded either as a raw data word or as control fields
 */
package fir_regmap_pkg;

	// --------------------------------------------------
	// address space
	// --------------------------------------------------

	// register port address width
	localparam int addr_width = 12;

	// control/status word, ap_start / ap_done / ap_idle
	localparam logic [addr_width-1:0] addr_ctrl = 12'h000;

	// data length, number of results in one frame
	localparam logic [addr_width-1:0] addr_len = 12'h010;

	// coefficient i at addr_tap_base + 4*i
	localparam logic [addr_width-1:0] addr_tap_base = 12'h020;

	// --------------------------------------------------
	// control/status word
	// --------------------------------------------------

	// raw view on wdata/rdata, ctrl view for the flag bits
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			// reads back as zero
			logic [28:0] rsvd;
			// bit 2, engine waiting for a start
			logic        ap_idle;
			// bit 1, cleared by a status read
			logic        ap_done;
			// bit 0, write only
			logic        ap_start;
		} ctrl;
	} ctrl_word_t;

endpackage

/* design/fir_dsp_pkg.sv */
/*
 * fir datapath types
 * sample, coefficient and accumulator words plus the default tap count
 */
package fir_dsp_pkg;

	// --------------------------------------------------
	// word widths
	// --------------------------------------------------
	localparam int data_width = 32;

	// input sample from the stream port
	typedef logic signed [data_width-1:0] sample_t;
	// filter coefficient
	typedef logic signed [data_width-1:0] coef_t;
	// accumulator and result, wraps modulo 2^32
	typedef logic signed [data_width-1:0] acc_t;

	// taps when the top level does not override
	localparam int default_num_taps = 11;

endpackage

/* design/fir_cfg_regs.sv */
/*
 * fir configuration registers
 * register port slave holding the coefficients, the data length and the
 * ap_start / ap_done / ap_idle control flags, steering the mac engine
 */
`timescale 1ns/1ps

module fir_cfg_regs #(
	parameter int num_taps = fir_dsp_pkg::default_num_taps,
	localparam int idx_w = $clog2(num_taps)
) (
	input  logic                                  axis_clk,
	input  logic                                  axis_rst_n,
	input  logic                                  awvalid,
	input  logic [fir_regmap_pkg::addr_width-1:0] awaddr,
	output logic                                  awready,
	input  logic                                  wvalid,
	input  fir_regmap_pkg::ctrl_word_t            wdata,
	output logic                                  wready,
	input  logic                                  arvalid,
	input  logic [fir_regmap_pkg::addr_width-1:0] araddr,
	output logic                                  arready,
	output logic                                  rvalid,
	input  logic                                  rready,
	output fir_regmap_pkg::ctrl_word_t            rdata,
	input  logic [idx_w-1:0]                      tap_idx,
	input  logic                                  frame_done,
	output logic                                  start,
	output logic [31:0]                           data_length,
	output fir_dsp_pkg::coef_t                    tap_coef
);

	// coefficient address in range and word aligned
	function automatic logic tap_hit(input logic [fir_regmap_pkg::addr_width-1:0] addr);
		logic [fir_regmap_pkg::addr_width-1:0] off;
		off = addr - fir_regmap_pkg::addr_tap_base;
		return (addr >= fir_regmap_pkg::addr_tap_base) && (off[1:0] == 2'b00) &&
			(off[fir_regmap_pkg::addr_width-1:2] < num_taps);
	endfunction

	// coefficient index from a byte address
	function automatic logic [idx_w-1:0] tap_sel(input logic [fir_regmap_pkg::addr_width-1:0] addr);
		logic [fir_regmap_pkg::addr_width-1:0] off;
		off = addr - fir_regmap_pkg::addr_tap_base;
		return off[idx_w+1:2];
	endfunction

	fir_dsp_pkg::coef_t         coefs [num_taps];
	fir_regmap_pkg::ctrl_word_t status_word;
	fir_regmap_pkg::ctrl_word_t rd_word;
	logic                       ap_done;
	logic                       ap_idle;
	logic                       rd_pend;
	logic                       rd_ctrl;
	logic                       wr_en;
	logic                       rd_en;

	// --------------------------------------------------
	// handshakes
	// --------------------------------------------------

	// address and data taken together, same edge
	assign wr_en   = awvalid && wvalid;
	assign awready = wr_en;
	assign wready  = wr_en;

	// one read outstanding at a time
	assign arready = !rd_pend;
	assign rvalid  = rd_pend;
	assign rd_en   = arvalid && arready;

	assign tap_coef = coefs[tap_idx];

	// --------------------------------------------------
	// control state
	// --------------------------------------------------
	always_ff @(posedge axis_clk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			start       <= 1'b0;
			ap_idle     <= 1'b1;
			ap_done     <= 1'b0;
			data_length <= '0;
			rd_pend     <= 1'b0;
			rd_ctrl     <= 1'b0;
		end else begin
			start <= 1'b0;
			// config is frozen while a frame runs
			if (wr_en && ap_idle) begin
				if (awaddr == fir_regmap_pkg::addr_ctrl && wdata.ctrl.ap_start) begin
					start   <= 1'b1;
					ap_idle <= 1'b0;
				end
				if (awaddr == fir_regmap_pkg::addr_len)
					data_length <= wdata.raw;
			end
			if (rd_en) begin
				rd_pend <= 1'b1;
				rd_ctrl <= (araddr == fir_regmap_pkg::addr_ctrl);
			end else if (rvalid && rready) begin
				rd_pend <= 1'b0;
			end
			// status read acknowledges done
			if (rvalid && rready && rd_ctrl)
				ap_done <= 1'b0;
			// last result out, back to idle
			if (frame_done) begin
				ap_done <= 1'b1;
				ap_idle <= 1'b1;
			end
		end
	end

	// coefficient array
	always_ff @(posedge axis_clk) begin
		if (wr_en && ap_idle && tap_hit(awaddr))
			coefs[tap_sel(awaddr)] <= wdata.raw;
	end

	// --------------------------------------------------
	// readback
	// --------------------------------------------------

	// ap_start never reads back
	always_comb begin
		status_word              = '0;
		status_word.ctrl.ap_done = ap_done;
		status_word.ctrl.ap_idle = ap_idle;
	end

	// unmapped reads as zero
	always_comb begin
		rd_word = '0;
		if (araddr == fir_regmap_pkg::addr_ctrl)
			rd_word = status_word;
		else if (araddr == fir_regmap_pkg::addr_len)
			rd_word.raw = data_length;
		else if (tap_hit(araddr))
			rd_word.raw = coefs[tap_sel(araddr)];
	end

	// snapshot at accept, held until rready
	always_ff @(posedge axis_clk) begin
		if (rd_en)
			rdata <= rd_word;
	end

	// start only ever leaves idle
	a_start_from_idle: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
		start |-> ($past(ap_idle) && !ap_idle));

	a_rdata_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
		(rvalid && !rready) |=> (rvalid && $stable(rdata)));

endmodule

/* design/fir_mac_engine.sv */
/*
 * fir mac engine
 * sample window, tap sequencer and accumulator, one product per cycle,
 * with a result register held under sm_tready back-pressure
 */
`timescale 1ns/1ps

module fir_mac_engine #(
	parameter int num_taps = fir_dsp_pkg::default_num_taps,
	localparam int idx_w = $clog2(num_taps)
) (
	input  logic                 axis_clk,
	input  logic                 axis_rst_n,
	input  logic                 start,
	input  logic [31:0]          data_length,
	input  fir_dsp_pkg::coef_t   tap_coef,
	output logic [idx_w-1:0]     tap_idx,
	output logic                 frame_done,
	input  logic                 ss_tvalid,
	input  fir_dsp_pkg::sample_t ss_tdata,
	output logic                 ss_tready,
	output logic                 sm_tvalid,
	input  logic                 sm_tready,
	output fir_dsp_pkg::acc_t    sm_tdata,
	output logic                 sm_tlast
);

	fir_dsp_pkg::sample_t window [num_taps];
	fir_dsp_pkg::acc_t    acc;
	fir_dsp_pkg::acc_t    prod;
	logic [31:0]          res_cnt;
	logic                 running;
	logic                 busy;
	logic                 mac_on;
	logic                 mac_fin;
	logic                 ss_fire;
	logic                 sm_fire;

	// one sample in flight until its result leaves
	assign ss_tready  = running && !busy;
	assign ss_fire    = ss_tvalid && ss_tready;
	assign sm_fire    = sm_tvalid && sm_tready;
	assign frame_done = sm_fire && sm_tlast;

	// lower 32 bits of the product
	assign prod = window[tap_idx] * tap_coef;

	// --------------------------------------------------
	// sequencer
	// --------------------------------------------------
	always_ff @(posedge axis_clk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			running   <= 1'b0;
			busy      <= 1'b0;
			mac_on    <= 1'b0;
			mac_fin   <= 1'b0;
			tap_idx   <= '0;
			res_cnt   <= '0;
			sm_tvalid <= 1'b0;
			sm_tlast  <= 1'b0;
		end else if (start) begin
			// new frame
			running   <= 1'b1;
			busy      <= 1'b0;
			mac_on    <= 1'b0;
			mac_fin   <= 1'b0;
			tap_idx   <= '0;
			res_cnt   <= '0;
			sm_tvalid <= 1'b0;
			sm_tlast  <= 1'b0;
		end else begin
			mac_fin <= 1'b0;
			if (ss_fire) begin
				busy    <= 1'b1;
				mac_on  <= 1'b1;
				tap_idx <= '0;
			end
			// one tap per cycle, num_taps cycles
			if (mac_on) begin
				if (tap_idx == num_taps - 1) begin
					mac_on  <= 1'b0;
					mac_fin <= 1'b1;
					tap_idx <= '0;
				end else begin
					tap_idx <= tap_idx + 1'b1;
				end
			end
			// result register loads one cycle after the last add
			if (mac_fin) begin
				sm_tvalid <= 1'b1;
				sm_tlast  <= (res_cnt + 32'd1 == data_length);
			end
			if (sm_fire) begin
				sm_tvalid <= 1'b0;
				sm_tlast  <= 1'b0;
				busy      <= 1'b0;
				res_cnt   <= res_cnt + 32'd1;
				if (sm_tlast)
					running <= 1'b0;
			end
		end
	end

	// --------------------------------------------------
	// datapath
	// --------------------------------------------------
	always_ff @(posedge axis_clk) begin
		// newest sample at position 0
		if (start) begin
			for (int i = 0; i < num_taps; i++)
				window[i] <= '0;
		end else if (ss_fire) begin
			window[0] <= ss_tdata;
			for (int i = 1; i < num_taps; i++)
				window[i] <= window[i-1];
		end
		if (ss_fire)
			acc <= '0;
		else if (mac_on)
			acc <= acc + prod;
		if (mac_fin)
			sm_tdata <= acc;
	end

	a_one_in_flight: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
		!(ss_tready && sm_tvalid));

	// result, last flag and valid hold under back-pressure
	a_result_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
		(sm_tvalid && !sm_tready) |=> (sm_tvalid && $stable(sm_tdata) && $stable(sm_tlast)));

	a_tap_range: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
		tap_idx < num_taps);

endmodule

/* design/fir_top.sv */
/*
 * fir filter top
 * joins the register block to the mac engine
 */
`timescale 1ns/1ps

module fir_top #(
	parameter int num_taps = fir_dsp_pkg::default_num_taps
) (
	input  logic                                  axis_clk,
	input  logic                                  axis_rst_n,
	// register port
	input  logic                                  awvalid,
	input  logic [fir_regmap_pkg::addr_width-1:0] awaddr,
	output logic                                  awready,
	input  logic                                  wvalid,
	input  fir_regmap_pkg::ctrl_word_t            wdata,
	output logic                                  wready,
	input  logic                                  arvalid,
	input  logic [fir_regmap_pkg::addr_width-1:0] araddr,
	output logic                                  arready,
	output logic                                  rvalid,
	input  logic                                  rready,
	output fir_regmap_pkg::ctrl_word_t            rdata,
	// sample in, result out
	input  logic                                  ss_tvalid,
	input  fir_dsp_pkg::sample_t                  ss_tdata,
	output logic                                  ss_tready,
	output logic                                  sm_tvalid,
	input  logic                                  sm_tready,
	output fir_dsp_pkg::acc_t                     sm_tdata,
	output logic                                  sm_tlast
);

	localparam int idx_w = $clog2(num_taps);

	// --------------------------------------------------
	// regs to engine
	// --------------------------------------------------
	logic                 start;
	logic [31:0]          data_length;
	fir_dsp_pkg::coef_t   tap_coef;
	logic [idx_w-1:0]     tap_idx;
	logic                 frame_done;

	fir_cfg_regs #(.num_taps(num_taps)) fir_cfg_regs_i (
		.axis_clk, .axis_rst_n,
		.awvalid, .awaddr, .awready, .wvalid, .wdata, .wready,
		.arvalid, .araddr, .arready, .rvalid, .rready, .rdata,
		.tap_idx, .frame_done, .start, .data_length, .tap_coef
	);

	fir_mac_engine #(.num_taps(num_taps)) fir_mac_engine_i (
		.axis_clk, .axis_rst_n,
		.start, .data_length, .tap_coef, .tap_idx, .frame_done,
		.ss_tvalid, .ss_tdata, .ss_tready,
		.sm_tvalid, .sm_tready, .sm_tdata, .sm_tlast
	);

endmodule

/* dv/fir_tb.sv */
/*
 * fir testbench
 * programs the register port, streams random frames through fir_top and
 * compares every result with a reference model, under a watchdog
 */
`timescale 1ns/1ps

module fir_tb;

	localparam int num_taps  = fir_dsp_pkg::default_num_taps;
	localparam int len_a     = 12;
	localparam int len_b     = 14;
	// longest run of sm_tready low
	localparam int max_stall = 4;
	// frame samples x (mac latency + worst stall) x 4 ns, plus register traffic
	localparam real timeout_ns = (len_a + len_b) * (num_taps + 1 + max_stall) * 4.0 + 4000.0;

	logic axis_clk = 1'b0;
	logic axis_rst_n;
	logic awvalid, wvalid, arvalid, rready, ss_tvalid, sm_tready;
	logic awready, wready, arready, rvalid, ss_tready, sm_tvalid, sm_tlast;
	logic [fir_regmap_pkg::addr_width-1:0] awaddr, araddr;
	fir_regmap_pkg::ctrl_word_t wdata, rdata;
	fir_dsp_pkg::sample_t ss_tdata;
	fir_dsp_pkg::acc_t    sm_tdata;

	// model state
	fir_dsp_pkg::coef_t   h [num_taps];
	fir_dsp_pkg::sample_t xs [$];
	int          frame_len, res_idx, low_run;
	bit          stall_on;
	logic [31:0] stim_seed = 32'h474e;
	logic [31:0] rdy_seed = 32'h474e;
	logic [31:0] rdy_rand;
	string       test_name;
	int          err_result, err_reg, err_last, err_timing, err_other;

	always #2 axis_clk = ~axis_clk;

	fir_top fir_top_i (.*);

	function automatic logic [31:0] lcg(inout logic [31:0] s);
		s = s * 32'd1664525 + 32'd1013904223;
		return s;
	endfunction

	// y[n] = sum h[i]*x[n-i], window empty at start
	function automatic fir_dsp_pkg::acc_t ref_fir(int n);
		fir_dsp_pkg::acc_t y;
		y = '0;
		for (int i = 0; i < num_taps; i++)
			if (n - i >= 0)
				y = y + h[i] * xs[n-i];
		return y;
	endfunction

	function automatic fir_regmap_pkg::ctrl_word_t status_word(logic done, logic idle);
		fir_regmap_pkg::ctrl_word_t w;
		w = '0;
		w.ctrl.ap_done = done;
		w.ctrl.ap_idle = idle;
		return w;
	endfunction

	function automatic logic [fir_regmap_pkg::addr_width-1:0] tap_addr(int i);
		return fir_regmap_pkg::addr_tap_base + 4 * i;
	endfunction

	// --------------------------------------------------
	// compare tasks
	// --------------------------------------------------
	task automatic check_result(string name, fir_dsp_pkg::acc_t exp, fir_dsp_pkg::acc_t act);
		if (act !== exp) begin
			err_result++;
			$display("ERR %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_reg(string name, fir_regmap_pkg::ctrl_word_t exp,
		fir_regmap_pkg::ctrl_word_t act);
		if (act !== exp) begin
			err_reg++;
			$display("ERR %s: expected %08h, actual %08h", name, exp.raw, act.raw);
		end
	endtask

	task automatic check_last(string name, bit exp, bit act);
		if (act !== exp) begin
			err_last++;
			$display("ERR %s: expected %0b, actual %0b", name, exp, act);
		end
	endtask

	// --------------------------------------------------
	// register port
	// --------------------------------------------------
	// address and data together, taken at the next edge
	task automatic write_reg(logic [fir_regmap_pkg::addr_width-1:0] addr, logic [31:0] val);
		@(posedge axis_clk);
		awvalid   <= 1'b1;
		wvalid    <= 1'b1;
		awaddr    <= addr;
		wdata.raw <= val;
		// both ready in the same cycle as both valid
		@(negedge axis_clk);
		if (!(awready && wready)) begin
			err_other++;
			$display("write to %03h in %s not accepted, awready %b wready %b", addr,
				test_name, awready, wready);
		end
		@(posedge axis_clk);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
	endtask

	task automatic read_reg(logic [fir_regmap_pkg::addr_width-1:0] addr,
		output fir_regmap_pkg::ctrl_word_t val);
		@(posedge axis_clk);
		arvalid <= 1'b1;
		araddr  <= addr;
		rready  <= 1'b1;
		do begin
			@(negedge axis_clk);
		end while (!arready);
		@(posedge axis_clk);
		arvalid <= 1'b0;
		do begin
			@(negedge axis_clk);
		end while (!rvalid);
		val = rdata;
		// rready still high here, so this edge completes the read
		@(posedge axis_clk);
		rready <= 1'b0;
	endtask

	task automatic load_taps();
		for (int i = 0; i < num_taps; i++) begin
			h[i] = lcg(stim_seed);
			write_reg(tap_addr(i), h[i]);
		end
	endtask

	task automatic check_taps(string name);
		fir_regmap_pkg::ctrl_word_t rd;
		fir_regmap_pkg::ctrl_word_t exp;
		for (int i = 0; i < num_taps; i++) begin
			read_reg(tap_addr(i), rd);
			exp.raw = h[i];
			check_reg($sformatf("%s tap %0d", name, i), exp, rd);
		end
	endtask

	// --------------------------------------------------
	// streams
	// --------------------------------------------------
	// one sample at a time, then time the result
	task automatic drive_samples(int len);
		int cyc;
		for (int n = 0; n < len; n++) begin
			@(posedge axis_clk);
			ss_tvalid <= 1'b1;
			ss_tdata  <= xs[n];
			do begin
				@(negedge axis_clk);
			end while (!ss_tready);
			@(posedge axis_clk);
			ss_tvalid <= 1'b0;
			cyc = 0;
			do begin
				@(posedge axis_clk);
				cyc++;
				@(negedge axis_clk);
			end while (!sm_tvalid);
			if (cyc != num_taps + 1) begin
				err_timing++;
				$display("ERR %s latency %0d: expected %0d, actual %0d", test_name, n,
					num_taps + 1, cyc);
			end
		end
	endtask

	// random back-pressure, bounded by max_stall
	always @(posedge axis_clk) begin
		rdy_rand = lcg(rdy_seed);
		if (!stall_on || low_run >= max_stall || rdy_rand[16]) begin
			sm_tready <= 1'b1;
			low_run = 0;
		end else begin
			sm_tready <= 1'b0;
			low_run++;
		end
	end

	// transfer at the coming edge
	always @(negedge axis_clk) begin
		if (axis_rst_n && sm_tvalid && sm_tready) begin
			if (res_idx >= frame_len) begin
				err_other++;
				$display("extra result after the end of the frame in %s", test_name);
			end else begin
				check_result($sformatf("%s result %0d", test_name, res_idx),
					ref_fir(res_idx), sm_tdata);
				check_last($sformatf("%s tlast %0d", test_name, res_idx),
					res_idx == frame_len - 1, sm_tlast);
			end
			res_idx++;
		end
	end

	task automatic run_frame(string name, int len, bit stall, bit poke);
		fir_regmap_pkg::ctrl_word_t rd;
		test_name = name;
		xs.delete();
		for (int n = 0; n < len; n++)
			xs.push_back(lcg(stim_seed));
		frame_len = len;
		res_idx   = 0;
		write_reg(fir_regmap_pkg::addr_len, len);
		stall_on <= stall;
		write_reg(fir_regmap_pkg::addr_ctrl, 32'h1);
		fork
			drive_samples(len);
			begin
				// engine busy, these must not land
				if (poke)
					for (int i = 0; i < num_taps; i++)
						write_reg(tap_addr(i), ~h[i]);
				wait (res_idx == len);
			end
		join
		stall_on <= 1'b0;
		read_reg(fir_regmap_pkg::addr_ctrl, rd);
		check_reg({name, " status after frame"}, status_word(1'b1, 1'b1), rd);
		read_reg(fir_regmap_pkg::addr_ctrl, rd);
		check_reg({name, " status after done read"}, status_word(1'b0, 1'b1), rd);
	endtask

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial begin
		fir_regmap_pkg::ctrl_word_t rd;
		axis_rst_n = 1'b0;
		awvalid    = 1'b0;
		wvalid     = 1'b0;
		arvalid    = 1'b0;
		rready     = 1'b0;
		awaddr     = '0;
		araddr     = '0;
		wdata      = '0;
		ss_tvalid  = 1'b0;
		ss_tdata   = '0;
		sm_tready  = 1'b1;
		stall_on   = 1'b0;
		low_run    = 0;
		frame_len  = 0;
		res_idx    = 0;
		test_name  = "reset";
		{err_result, err_reg, err_last, err_timing, err_other} = '0;
		repeat (5) @(posedge axis_clk);
		axis_rst_n <= 1'b1;

		read_reg(fir_regmap_pkg::addr_ctrl, rd);
		check_reg("reset status", status_word(1'b0, 1'b1), rd);
		load_taps();
		write_reg(fir_regmap_pkg::addr_len, len_a);
		read_reg(fir_regmap_pkg::addr_len, rd);
		check_reg("length readback", 32'(len_a), rd);
		check_taps("tap readback");

		run_frame("frame_a", len_a, 1'b0, 1'b0);
		// new taps, stalls, writes during the frame
		load_taps();
		run_frame("frame_b", len_b, 1'b1, 1'b1);
		check_taps("taps after frame_b");

		repeat (4) @(posedge axis_clk);
		$display("errors: result %0d register %0d last %0d timing %0d other %0d",
			err_result, err_reg, err_last, err_timing, err_other);
		if (err_result + err_reg + err_last + err_timing + err_other == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	initial begin
		#(timeout_ns);
		$display("watchdog expired before the test sequence finished");
		$display("tests failed");
		$finish;
	end

endmodule

/* verilog.f */
design/fir_regmap_pkg.sv
design/fir_dsp_pkg.sv
design/fir_cfg_regs.sv
design/fir_mac_engine.sv
design/fir_top.sv
dv/fir_tb.sv

/* Bender.yml */
package:
  name: fir_filter

sources:
  # packages first, then the RTL modules
  - design/fir_regmap_pkg.sv
  - design/fir_dsp_pkg.sv
  - design/fir_cfg_regs.sv
  - design/fir_mac_engine.sv
  - design/fir_top.sv

  # testbench
  - target: simulation
    files:
      - dv/fir_tb.sv
